// File: hdl/bp_pkg.sv
// Branch prediction front-end package
// Shared widths, the two-bit counter encoding and the packed structs
// exchanged between fetch, predictor and retire training queue

`default_nettype none

package bp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Global history length
    localparam int BP_GHR_WIDTH     = 8;
    // Byte offset within a 32-bit instruction word
    localparam int BP_PC_ALIGN_BITS = 2;
    // BTB tag, taken just above the BTB index
    localparam int BP_BTB_TAG_BITS  = 8;

    // Saturating counter, MSB is the taken prediction
    typedef enum logic [1:0] {
        STRONGLY_NOT_TAKEN = 2'd0,
        WEAKLY_NOT_TAKEN   = 2'd1,
        WEAKLY_TAKEN       = 2'd2,
        STRONGLY_TAKEN     = 2'd3
    } BP_COUNTER_STATE;

    //////////////////////////////////////////////////////////////////////
    // Interface structs
    //////////////////////////////////////////////////////////////////////

    // Fetch to predictor
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } BP_PREDICT_REQUEST;

    // Predictor to fetch, same cycle
    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic [31:0]             target;
        logic [BP_GHR_WIDTH-1:0] ghr_snapshot;
    } BP_PREDICT_RESPONSE;

    // Resolved branch from retire
    // actual_target is always the correct next pc
    typedef struct packed {
        logic                    valid;
        logic [31:0]             pc;
        logic [BP_GHR_WIDTH-1:0] ghr_snapshot;
        logic                    mispredict;
        logic                    actual_taken;
        logic [31:0]             actual_target;
    } BP_TRAIN_REQUEST;

    // Fetch output toward decode
    typedef struct packed {
        logic                    valid;
        logic [31:0]             pc;
        logic                    taken;
        logic [31:0]             target;
        logic [BP_GHR_WIDTH-1:0] ghr_snapshot;
    } BP_FETCH_PACKET;

    // One BTB slot payload, valid bits kept apart
    typedef struct packed {
        logic [BP_BTB_TAG_BITS-1:0] tag;
        logic [31:0]                target;
    } BP_BTB_ENTRY;

endpackage

`default_nettype wire

// File: hdl/bp.sv
// Gshare branch predictor with tagged BTB
// Combinational prediction from the fetch request, table training from
// the retire queue, global history kept here and rebuilt on mispredict

`timescale 1ns/1ps
`default_nettype none

module bp #(
    parameter int PHT_BITS = 10,
    parameter int BTB_BITS = 6
) (
    input  logic                       clock,
    input  logic                       reset,
    input  bp_pkg::BP_PREDICT_REQUEST  predict_req_i,
    output bp_pkg::BP_PREDICT_RESPONSE predict_resp_o,
    input  bp_pkg::BP_TRAIN_REQUEST    train_req_i
);

    localparam int PHT_ENTRIES = 1 << PHT_BITS;
    localparam int BTB_ENTRIES = 1 << BTB_BITS;
    localparam int GHR_W       = bp_pkg::BP_GHR_WIDTH;
    localparam int TAG_W       = bp_pkg::BP_BTB_TAG_BITS;
    localparam int ALIGN       = bp_pkg::BP_PC_ALIGN_BITS;

    // History and tables
    logic [GHR_W-1:0]        ghr;
    logic [GHR_W-1:0]        ghr_next;
    bp_pkg::BP_COUNTER_STATE pht [PHT_ENTRIES];
    logic [BTB_ENTRIES-1:0]  btb_valid;
    bp_pkg::BP_BTB_ENTRY     btb [BTB_ENTRIES];

    // Lookup side
    logic [PHT_BITS-1:0]     pred_pht_idx;
    logic [BTB_BITS-1:0]     pred_btb_idx;
    logic [TAG_W-1:0]        pred_tag;
    logic                    pred_taken;
    logic                    btb_hit;

    // Training side
    logic [PHT_BITS-1:0]     train_pht_idx;
    logic [BTB_BITS-1:0]     train_btb_idx;
    logic [TAG_W-1:0]        train_tag;
    logic                    mispredict;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Gshare hash, history zero-extended into the index
    function automatic logic [PHT_BITS-1:0] pht_index(
        input logic [31:0]      pc,
        input logic [GHR_W-1:0] hist
    );
        return pc[ALIGN +: PHT_BITS] ^ PHT_BITS'(hist);
    endfunction

    // Two-bit saturating step
    function automatic bp_pkg::BP_COUNTER_STATE counter_step(
        input bp_pkg::BP_COUNTER_STATE cur,
        input logic                    taken
    );
        case (cur)
            bp_pkg::STRONGLY_NOT_TAKEN:
                return taken ? bp_pkg::WEAKLY_NOT_TAKEN : bp_pkg::STRONGLY_NOT_TAKEN;
            bp_pkg::WEAKLY_NOT_TAKEN:
                return taken ? bp_pkg::WEAKLY_TAKEN : bp_pkg::STRONGLY_NOT_TAKEN;
            bp_pkg::WEAKLY_TAKEN:
                return taken ? bp_pkg::STRONGLY_TAKEN : bp_pkg::WEAKLY_NOT_TAKEN;
            default:
                return taken ? bp_pkg::STRONGLY_TAKEN : bp_pkg::WEAKLY_TAKEN;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Prediction
    //////////////////////////////////////////////////////////////////////

    assign pred_pht_idx = pht_index(predict_req_i.pc, ghr);
    assign pred_btb_idx = predict_req_i.pc[ALIGN +: BTB_BITS];
    assign pred_tag     = predict_req_i.pc[ALIGN + BTB_BITS +: TAG_W];

    // Counter MSB gives direction
    assign pred_taken = pht[pred_pht_idx][1];
    assign btb_hit    = btb_valid[pred_btb_idx] && (btb[pred_btb_idx].tag == pred_tag);

    always_comb begin
        predict_resp_o.valid        = predict_req_i.valid;
        predict_resp_o.taken        = pred_taken;
        predict_resp_o.ghr_snapshot = ghr;
        // Taken without a BTB hit still falls through
        if (pred_taken && btb_hit) begin
            predict_resp_o.target = btb[pred_btb_idx].target;
        end else begin
            predict_resp_o.target = predict_req_i.pc + 32'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Training and history
    //////////////////////////////////////////////////////////////////////

    // Indexed with the history seen at prediction time
    assign train_pht_idx = pht_index(train_req_i.pc, train_req_i.ghr_snapshot);
    assign train_btb_idx = train_req_i.pc[ALIGN +: BTB_BITS];
    assign train_tag     = train_req_i.pc[ALIGN + BTB_BITS +: TAG_W];
    assign mispredict    = train_req_i.valid && train_req_i.mispredict;

    // Mispredict wins over a same-cycle prediction
    always_comb begin
        ghr_next = ghr;
        if (mispredict) begin
            ghr_next = {train_req_i.ghr_snapshot[GHR_W-2:0], train_req_i.actual_taken};
        end else if (predict_req_i.valid) begin
            ghr_next = {ghr[GHR_W-2:0], pred_taken};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ghr       <= '0;
            btb_valid <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= bp_pkg::STRONGLY_NOT_TAKEN;
            end
        end else begin
            ghr <= ghr_next;
            if (train_req_i.valid) begin
                pht[train_pht_idx] <= counter_step(pht[train_pht_idx], train_req_i.actual_taken);
                // Only taken branches allocate
                if (train_req_i.actual_taken) begin
                    btb_valid[train_btb_idx] <= 1'b1;
                end
            end
        end
    end

    // BTB payload
    always_ff @(posedge clock) begin
        if (train_req_i.valid && train_req_i.actual_taken) begin
            btb[train_btb_idx].tag    <= train_tag;
            btb[train_btb_idx].target <= train_req_i.actual_target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bp_train_queue.sv
// Retire-side training queue
// Circular FIFO of resolved branches, head drained into the predictor
// every cycle it is valid, one credit returned per drained entry

`timescale 1ns/1ps
`default_nettype none

module bp_train_queue #(
    parameter int TRAIN_QUEUE_DEPTH = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  bp_pkg::BP_TRAIN_REQUEST retire_i,
    output bp_pkg::BP_TRAIN_REQUEST train_req_o,
    output logic                    credit_o
);

    localparam int PTR_W = (TRAIN_QUEUE_DEPTH > 1) ? $clog2(TRAIN_QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(TRAIN_QUEUE_DEPTH + 1);

    // Storage
    bp_pkg::BP_TRAIN_REQUEST mem [TRAIN_QUEUE_DEPTH];

    // Pointers and occupancy
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic credit_q;

    // Wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(TRAIN_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Push and pop
    //////////////////////////////////////////////////////////////////////

    // Retire only sends while holding a credit
    assign push = retire_i.valid;

    // Predictor never stalls, head leaves whenever present
    assign pop = (count != '0);

    always_comb begin
        train_req_o       = mem[rd_ptr];
        train_req_o.valid = pop;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= retire_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Credit return
    //////////////////////////////////////////////////////////////////////

    // One cycle after each pop
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= pop;
        end
    end

    assign credit_o = credit_q;

endmodule

`default_nettype wire

// File: hdl/bp_fetch_seq.sv
// Fetch PC sequencer
// Holds the fetch pc, asks the predictor each ready cycle, follows the
// predicted target and takes redirects from mispredicting branches

`timescale 1ns/1ps
`default_nettype none

module bp_fetch_seq #(
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       fetch_ready_i,
    input  bp_pkg::BP_TRAIN_REQUEST    train_req_i,
    output bp_pkg::BP_PREDICT_REQUEST  predict_req_o,
    input  bp_pkg::BP_PREDICT_RESPONSE predict_resp_i,
    output bp_pkg::BP_FETCH_PACKET     fetch_o
);

    // Current fetch address
    logic [31:0] pc_q;

    logic redirect;
    logic fetch_valid;

    //////////////////////////////////////////////////////////////////////
    // Request and redirect
    //////////////////////////////////////////////////////////////////////

    // Drained mispredict from the training queue
    assign redirect = train_req_i.valid && train_req_i.mispredict;

    // No fetch in the redirect cycle, keeps GHR recovery clean
    assign fetch_valid = fetch_ready_i && !redirect;

    always_comb begin
        predict_req_o.valid = fetch_valid;
        predict_req_o.pc    = pc_q;
    end

    //////////////////////////////////////////////////////////////////////
    // PC register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect) begin
            // Correct next pc from retire
            pc_q <= train_req_i.actual_target;
        end else if (fetch_valid) begin
            pc_q <= predict_resp_i.target;
        end
        // Back-pressure holds the pc
    end

    // Outgoing packet, prediction fields straight from the predictor
    always_comb begin
        fetch_o.valid        = predict_resp_i.valid;
        fetch_o.pc           = pc_q;
        fetch_o.taken        = predict_resp_i.taken;
        fetch_o.target       = predict_resp_i.target;
        fetch_o.ghr_snapshot = predict_resp_i.ghr_snapshot;
    end

endmodule

`default_nettype wire

// File: hdl/bp_frontend_top.sv
// Branch prediction front-end top
// Sets the predictor, queue and fetch parameters and wires the fetch
// sequencer, gshare predictor and retire training queue together

`timescale 1ns/1ps
`default_nettype none

module bp_frontend_top #(
    parameter int          PHT_BITS          = 10,
    parameter int          BTB_BITS          = 6,
    parameter int          TRAIN_QUEUE_DEPTH = 4,
    parameter logic [31:0] RESET_PC          = 32'h0000_1000
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    fetch_ready_i,
    output bp_pkg::BP_FETCH_PACKET  fetch_o,
    input  bp_pkg::BP_TRAIN_REQUEST retire_i,
    output logic                    credit_o
);

    // Fetch to predictor, same cycle
    bp_pkg::BP_PREDICT_REQUEST  predict_req;
    bp_pkg::BP_PREDICT_RESPONSE predict_resp;
    // Queue head, shared by predictor and sequencer
    bp_pkg::BP_TRAIN_REQUEST    train_req;

    bp_fetch_seq #(
        .RESET_PC (RESET_PC)
    ) bp_fetch_seq_inst (
        .clock          (clock),
        .reset          (reset),
        .fetch_ready_i  (fetch_ready_i),
        .train_req_i    (train_req),
        .predict_req_o  (predict_req),
        .predict_resp_i (predict_resp),
        .fetch_o        (fetch_o)
    );

    bp #(
        .PHT_BITS (PHT_BITS),
        .BTB_BITS (BTB_BITS)
    ) bp_inst (
        .clock          (clock),
        .reset          (reset),
        .predict_req_i  (predict_req),
        .predict_resp_o (predict_resp),
        .train_req_i    (train_req)
    );

    bp_train_queue #(
        .TRAIN_QUEUE_DEPTH (TRAIN_QUEUE_DEPTH)
    ) bp_train_queue_inst (
        .clock       (clock),
        .reset       (reset),
        .retire_i    (retire_i),
        .train_req_o (train_req),
        .credit_o    (credit_o)
    );

endmodule

`default_nettype wire

// File: tb/bp_frontend_asserts.sv
// Training queue checker
// Occupancy bound, credit return one cycle after each pop,
// and no retire write into a full queue

`timescale 1ns/1ps
`default_nettype none

module bp_frontend_asserts #(
    parameter int TRAIN_QUEUE_DEPTH = 4
) (
    input logic                                     clock,
    input logic                                     reset,
    input logic [$clog2(TRAIN_QUEUE_DEPTH + 1)-1:0] count_i,
    input logic                                     push_i,
    input logic                                     pop_i,
    input logic                                     credit_i
);

    localparam int CNT_W = $clog2(TRAIN_QUEUE_DEPTH + 1);

    // Occupancy bounded by depth
    occupancy_bound: assert property (@(posedge clock) disable iff (reset)
        count_i <= CNT_W'(TRAIN_QUEUE_DEPTH))
        else $error("training queue occupancy above depth");

    // Credit exactly one cycle after a pop, never otherwise
    credit_after_pop: assert property (@(posedge clock) disable iff (reset)
        pop_i |=> credit_i)
        else $error("no credit returned after a pop");

    credit_without_pop: assert property (@(posedge clock) disable iff (reset)
        !pop_i |=> !credit_i)
        else $error("credit returned without a pop");

    // Retire holds no credit while full
    no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        (count_i == CNT_W'(TRAIN_QUEUE_DEPTH)) |-> !push_i)
        else $error("retire write into a full training queue");

endmodule

bind bp_train_queue bp_frontend_asserts #(
    .TRAIN_QUEUE_DEPTH (TRAIN_QUEUE_DEPTH)
) bp_frontend_asserts_inst (
    .clock    (clock),
    .reset    (reset),
    .count_i  (count),
    .push_i   (push),
    .pop_i    (pop),
    .credit_i (credit_o)
);

`default_nettype wire

// File: tb/bp_frontend_tb.sv
// Branch prediction front-end testbench
// Table-driven stimulus checked against a reference gshare and BTB model,
// with retire-side credit tracking and LFSR back-pressure

`timescale 1ns/1ps
`default_nettype none

module bp_frontend_tb;

    localparam int          PHT_BITS          = 10;
    localparam int          BTB_BITS          = 6;
    localparam int          TRAIN_QUEUE_DEPTH = 4;
    localparam logic [31:0] RESET_PC          = 32'h0000_1000;
    localparam int          GHR_W             = bp_pkg::BP_GHR_WIDTH;
    localparam int          TAG_W             = bp_pkg::BP_BTB_TAG_BITS;
    localparam int          ALIGN             = bp_pkg::BP_PC_ALIGN_BITS;
    // fetch_ready_i source per row
    localparam logic [1:0]  READY_LOW         = 2'd0;
    localparam logic [1:0]  READY_HIGH        = 2'd1;
    localparam logic [1:0]  READY_LFSR        = 2'd2;

    // One stimulus row with fields checked two cycles after its start
    typedef struct packed {
        int          cycles;
        logic [1:0]  ready_mode;
        logic        has_retire;
        logic [31:0] pc;
        logic        mispredict;
        logic        actual_taken;
        logic [31:0] actual_target;
        logic        check_row;
        logic [31:0] exp_pc;
        logic        exp_taken;
        logic [31:0] exp_target;
    } stim_row_t;

    logic                    clock = 1'b0;
    logic                    reset;
    logic                    fetch_ready_i;
    bp_pkg::BP_FETCH_PACKET  fetch_o;
    bp_pkg::BP_TRAIN_REQUEST retire_i;
    logic                    credit_o;

    //////////////////////////////////////////////////////////////////////
    // Reference model state
    //////////////////////////////////////////////////////////////////////

    logic [31:0]             m_pc;
    logic [GHR_W-1:0]        m_ghr;
    bp_pkg::BP_COUNTER_STATE m_pht [1 << PHT_BITS];
    logic                    m_btb_valid [1 << BTB_BITS];
    logic [TAG_W-1:0]        m_btb_tag [1 << BTB_BITS];
    logic [31:0]             m_btb_target [1 << BTB_BITS];
    // Training queue contents from the head
    bp_pkg::BP_TRAIN_REQUEST m_queue [$];
    logic                    m_credit;
    bp_pkg::BP_FETCH_PACKET  m_expect;

    // Retire side bookkeeping
    int          credits       = TRAIN_QUEUE_DEPTH;
    int          cycle_count   = 0;
    int          cycle_limit   = 200;
    logic [31:0] lfsr_state    = 32'hb616_8036;
    stim_row_t   stim_table [$];

    bp_frontend_top #(
        .PHT_BITS          (PHT_BITS),
        .BTB_BITS          (BTB_BITS),
        .TRAIN_QUEUE_DEPTH (TRAIN_QUEUE_DEPTH),
        .RESET_PC          (RESET_PC)
    ) bp_frontend_top_inst (
        .clock         (clock),
        .reset         (reset),
        .fetch_ready_i (fetch_ready_i),
        .fetch_o       (fetch_o),
        .retire_i      (retire_i),
        .credit_o      (credit_o)
    );

    always #20 clock = ~clock;

    // Run limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_fetch(input bp_pkg::BP_FETCH_PACKET got,
                               input bp_pkg::BP_FETCH_PACKET exp);
        if (got !== exp) begin
            $display("[FAIL] fetch_o got valid=%h pc=%h taken=%h target=%h ghr=%h",
                     got.valid, got.pc, got.taken, got.target, got.ghr_snapshot);
            $display("[FAIL] fetch_o exp valid=%h pc=%h taken=%h target=%h ghr=%h",
                     exp.valid, exp.pc, exp.taken, exp.target, exp.ghr_snapshot);
            stop_with_failure();
        end
    endtask

    task automatic check_credit(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] credit_o got %h expected %h", got, exp);
            stop_with_failure();
        end
    endtask

    // Galois step taken once per bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ 32'h8020_0003;
        end
        return shifted;
    endfunction

    function automatic logic ready_for_mode(input logic [1:0] mode);
        if (mode == READY_LFSR) begin
            lfsr_state = lfsr_next(lfsr_state);
            return lfsr_state[0];
        end
        return mode == READY_HIGH;
    endfunction

    function automatic void add_row(
        input int          cycles,
        input logic [1:0]  mode,
        input logic        has_ret,
        input logic [31:0] pc,
        input logic        misp,
        input logic        taken,
        input logic [31:0] tgt,
        input logic        chk,
        input logic [31:0] epc,
        input logic        etaken,
        input logic [31:0] etgt
    );
        stim_row_t row;
        row = '{cycles, mode, has_ret, pc, misp, taken, tgt, chk, epc, etaken, etgt};
        stim_table.push_back(row);
        cycle_limit = cycle_limit + cycles;
    endfunction

    function automatic void load_table();
        // Straight-line fetch followed by hold and random back-pressure
        add_row(8, READY_HIGH, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1, 32'h0000_1008, 1'b0, 32'h0000_100c);
        add_row(6, READY_LOW, 1'b0, '0, 1'b0, 1'b0, '0, 1'b1, 32'h0000_1020, 1'b0, 32'h0000_1024);
        add_row(40, READY_LFSR, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        // Two taken trainings of 0x2040 before a redirect onto it
        add_row(4, READY_HIGH, 1'b1, 32'h0000_2040, 1'b0, 1'b1, 32'h0000_3000, 1'b0, '0, 1'b0, '0);
        add_row(4, READY_HIGH, 1'b1, 32'h0000_2040, 1'b0, 1'b1, 32'h0000_3000, 1'b0, '0, 1'b0, '0);
        add_row(4, READY_HIGH, 1'b1, 32'h0000_2100, 1'b1, 1'b0, 32'h0000_2040,
                1'b1, 32'h0000_2040, 1'b1, 32'h0000_3000);
        // Alias at the same BTB slot with another tag
        add_row(4, READY_HIGH, 1'b1, 32'h0000_2100, 1'b1, 1'b0, 32'h0000_1040,
                1'b1, 32'h0000_1040, 1'b1, 32'h0000_1044);
        // Taken mispredict whose rebuilt history selects the trained counter
        add_row(4, READY_HIGH, 1'b1, 32'h0000_1044, 1'b1, 1'b1, 32'h0000_1044,
                1'b1, 32'h0000_1044, 1'b1, 32'h0000_1044);
        // Credit burst
        add_row(1, READY_HIGH, 1'b1, 32'h0000_6000, 1'b0, 1'b0, 32'h0000_6004, 1'b0, '0, 1'b0, '0);
        add_row(1, READY_HIGH, 1'b1, 32'h0000_6004, 1'b0, 1'b0, 32'h0000_6008, 1'b0, '0, 1'b0, '0);
        add_row(1, READY_HIGH, 1'b1, 32'h0000_6008, 1'b0, 1'b0, 32'h0000_600c, 1'b0, '0, 1'b0, '0);
        add_row(1, READY_HIGH, 1'b1, 32'h0000_600c, 1'b0, 1'b0, 32'h0000_6010, 1'b0, '0, 1'b0, '0);
        add_row(30, READY_LFSR, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        add_row(6, READY_HIGH, 1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    endfunction

    function automatic void model_reset();
        m_pc     = RESET_PC;
        m_ghr    = '0;
        m_credit = 1'b0;
        m_queue.delete();
        for (int i = 0; i < (1 << PHT_BITS); i++) begin
            m_pht[i] = bp_pkg::STRONGLY_NOT_TAKEN;
        end
        for (int i = 0; i < (1 << BTB_BITS); i++) begin
            m_btb_valid[i] = 1'b0;
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // One clock cycle to drive, check and advance the model
    //////////////////////////////////////////////////////////////////////

    task automatic run_cycle(input logic ready, input bp_pkg::BP_TRAIN_REQUEST ret);
        bp_pkg::BP_TRAIN_REQUEST head;
        logic                    head_valid;
        logic                    redirect;
        logic                    fire;
        logic                    ptaken;
        logic                    hit;
        logic [PHT_BITS-1:0]     pidx;
        logic [PHT_BITS-1:0]     tidx;
        logic [BTB_BITS-1:0]     bidx;
        logic [BTB_BITS-1:0]     tbidx;
        @(posedge clock);
        #2;
        fetch_ready_i = ready;
        retire_i      = ret;
        if (ret.valid) begin
            credits = credits - 1;
        end
        @(negedge clock);
        head_valid = (m_queue.size() != 0);
        head       = '0;
        if (head_valid) begin
            head = m_queue[0];
        end
        // Drained mispredict blocks this cycle's fetch
        redirect = head_valid && head.mispredict;
        fire     = ready && !redirect;
        pidx     = m_pc[ALIGN +: PHT_BITS] ^ {{(PHT_BITS - GHR_W){1'b0}}, m_ghr};
        bidx     = m_pc[ALIGN +: BTB_BITS];
        ptaken   = (m_pht[pidx] >= bp_pkg::WEAKLY_TAKEN);
        hit      = m_btb_valid[bidx] && (m_btb_tag[bidx] == m_pc[ALIGN + BTB_BITS +: TAG_W]);
        m_expect.valid        = fire;
        m_expect.pc           = m_pc;
        m_expect.taken        = ptaken;
        m_expect.target       = (ptaken && hit) ? m_btb_target[bidx] : m_pc + 32'd4;
        m_expect.ghr_snapshot = m_ghr;
        check_fetch(fetch_o, m_expect);
        check_credit(credit_o, m_credit);
        if (credit_o) begin
            credits = credits + 1;
        end
        // Training from the queue head indexed by its snapshot
        if (head_valid) begin
            tidx  = head.pc[ALIGN +: PHT_BITS] ^ {{(PHT_BITS - GHR_W){1'b0}}, head.ghr_snapshot};
            tbidx = head.pc[ALIGN +: BTB_BITS];
            if (head.actual_taken && m_pht[tidx] != bp_pkg::STRONGLY_TAKEN) begin
                m_pht[tidx] = bp_pkg::BP_COUNTER_STATE'(m_pht[tidx] + 2'd1);
            end else if (!head.actual_taken && m_pht[tidx] != bp_pkg::STRONGLY_NOT_TAKEN) begin
                m_pht[tidx] = bp_pkg::BP_COUNTER_STATE'(m_pht[tidx] - 2'd1);
            end
            if (head.actual_taken) begin
                m_btb_valid[tbidx]  = 1'b1;
                m_btb_tag[tbidx]    = head.pc[ALIGN + BTB_BITS +: TAG_W];
                m_btb_target[tbidx] = head.actual_target;
            end
        end
        if (redirect) begin
            m_ghr = {head.ghr_snapshot[GHR_W-2:0], head.actual_taken};
            m_pc  = head.actual_target;
        end else if (fire) begin
            m_ghr = {m_ghr[GHR_W-2:0], ptaken};
            m_pc  = m_expect.target;
        end
        // Head drains with the credit one cycle later
        m_credit = head_valid;
        if (head_valid) begin
            void'(m_queue.pop_front());
        end
        if (ret.valid) begin
            m_queue.push_back(ret);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        stim_row_t               row;
        bp_pkg::BP_TRAIN_REQUEST ret;
        bp_pkg::BP_FETCH_PACKET  tbl_expect;
        reset         = 1'b1;
        fetch_ready_i = 1'b0;
        retire_i      = '0;
        load_table();
        model_reset();
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int r = 0; r < stim_table.size(); r++) begin
            row = stim_table[r];
            ret = '0;
            if (row.has_retire) begin
                // Retire sends only while holding a credit
                while (credits == 0) begin
                    run_cycle(ready_for_mode(row.ready_mode), '0);
                end
                // Retire snapshots use zero history
                ret.valid         = 1'b1;
                ret.pc            = row.pc;
                ret.mispredict    = row.mispredict;
                ret.actual_taken  = row.actual_taken;
                ret.actual_target = row.actual_target;
            end
            for (int j = 0; j < row.cycles; j++) begin
                if (j == 0) begin
                    run_cycle(ready_for_mode(row.ready_mode), ret);
                end else begin
                    run_cycle(ready_for_mode(row.ready_mode), '0);
                end
                if (row.check_row && j == 2) begin
                    tbl_expect        = m_expect;
                    tbl_expect.pc     = row.exp_pc;
                    tbl_expect.taken  = row.exp_taken;
                    tbl_expect.target = row.exp_target;
                    check_fetch(fetch_o, tbl_expect);
                end
            end
        end
        // Wait for every credit to come home
        while (credits != TRAIN_QUEUE_DEPTH) begin
            run_cycle(1'b1, '0);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/bp_pkg.sv
hdl/bp.sv
hdl/bp_train_queue.sv
hdl/bp_fetch_seq.sv
hdl/bp_frontend_top.sv
tb/bp_frontend_asserts.sv
tb/bp_frontend_tb.sv

// File: Makefile
# Verilator build and run for the branch prediction front-end

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = bp_frontend_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
